//--- src/inflight_pkg.sv
`default_nettype none

package inflight_pkg;

  // physical register file
  localparam int NUM_REGS   = 128;
  localparam int REG_ADDR_W = 7;

  // port counts
  localparam int NUM_READ  = 4;
  localparam int NUM_WB    = 3;
  localparam int NUM_ALLOC = 2;

  // physical register number
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // clearing sweep after reset
  typedef enum logic
  {
    SWEEP_CLEAR,
    SWEEP_DONE
  } sweep_state_t;

endpackage

`default_nettype wire

//--- src/inflight_wb_if.sv
`timescale 1ns/1ps
`default_nettype none

interface inflight_wb_if
  import inflight_pkg::*;
();

  // writebacks as they arrive at the top
  logic [NUM_WB-1:0]      wb_valid;
  reg_addr_t [NUM_WB-1:0] wb_addr;

  // same writebacks one cycle later, on their way into the array
  logic [NUM_WB-1:0]      wb_valid_d;
  reg_addr_t [NUM_WB-1:0] wb_addr_d;

  // high until every entry has been cleared
  logic                   sweep_busy;

  modport source
  (
    output wb_valid,
    output wb_addr,
    output wb_valid_d,
    output wb_addr_d,
    output sweep_busy
  );

  modport sink
  (
    input wb_valid,
    input wb_addr,
    input wb_valid_d,
    input wb_addr_d,
    input sweep_busy
  );

endinterface

`default_nettype wire

//--- src/inflight_flags.sv
`timescale 1ns/1ps
`default_nettype none

module inflight_flags
  import inflight_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,

  // writeback strobes, clear the pending bit one cycle later
  input  logic [NUM_WB-1:0]         wb_valid,
  input  reg_addr_t [NUM_WB-1:0]    wb_addr,

  // allocation strobes, set the pending bit
  input  logic [NUM_ALLOC-1:0]      alloc_valid,
  input  reg_addr_t [NUM_ALLOC-1:0] alloc_addr,

  // per read port lookup
  input  reg_addr_t [NUM_READ-1:0]  look_addr,
  output logic [NUM_READ-1:0]       look_flag,

  inflight_wb_if.source             wb,

  output logic                      ready
);

  // one bit per physical register, high while its result is pending
  logic [NUM_REGS-1:0]    flags;

  sweep_state_t           state;
  reg_addr_t              sweep_addr;
  logic                   sweep_busy;
  logic                   sweep_last;

  logic [NUM_WB-1:0]      wb_valid_d;
  reg_addr_t [NUM_WB-1:0] wb_addr_d;

  assign sweep_busy = (state == SWEEP_CLEAR);
  assign sweep_last = (sweep_addr == reg_addr_t'(NUM_REGS - 1));
  assign ready      = (state == SWEEP_DONE);

  // sweep FSM, one entry per cycle after reset
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state      <= SWEEP_CLEAR;
      sweep_addr <= '0;
    end
    else
    begin
      case (state)
        SWEEP_CLEAR:
        begin
          sweep_addr <= sweep_addr + 1'b1;
          if (sweep_last)
          begin
            state <= SWEEP_DONE;
          end
        end
        default:
        begin
          state <= SWEEP_DONE;
        end
      endcase
    end
  end

  // writeback delay stage, strobes taken during the sweep are dropped
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wb_valid_d <= '0;
    end
    else if (sweep_busy)
    begin
      wb_valid_d <= '0;
    end
    else
    begin
      wb_valid_d <= wb_valid;
    end
  end

  always_ff @(posedge clk)
  begin
    wb_addr_d <= wb_addr;
  end

  // array update
  // clears first, sets last so an allocation wins over a writeback
  always_ff @(posedge clk)
  begin
    if (sweep_busy)
    begin
      flags[sweep_addr] <= 1'b0;
    end
    else
    begin
      for (int i = 0; i < NUM_WB; i++)
      begin
        if (wb_valid_d[i])
        begin
          flags[wb_addr_d[i]] <= 1'b0;
        end
      end
      for (int j = 0; j < NUM_ALLOC; j++)
      begin
        if (alloc_valid[j])
        begin
          flags[alloc_addr[j]] <= 1'b1;
        end
      end
    end
  end

  // combinational lookup
  always_comb
  begin
    for (int p = 0; p < NUM_READ; p++)
    begin
      look_flag[p] = flags[look_addr[p]];
    end
  end

  // writeback view for the read ports' bypass
  assign wb.wb_valid   = wb_valid;
  assign wb.wb_addr    = wb_addr;
  assign wb.wb_valid_d = wb_valid_d;
  assign wb.wb_addr_d  = wb_addr_d;
  assign wb.sweep_busy = sweep_busy;

endmodule

`default_nettype wire

//--- src/inflight_read_port.sv
`timescale 1ns/1ps
`default_nettype none

module inflight_read_port
  import inflight_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        rd_en,

  // source operand, sampled on rd_en
  input  reg_addr_t   rd_addr,
  input  logic        rd_oe,
  input  logic        rd_const,

  // lookup into the flag array
  output reg_addr_t   look_addr,
  input  logic        look_flag,

  inflight_wb_if.sink wb,

  output logic        rd_data
);

  reg_addr_t addr_q;
  logic      oe_q;
  logic      const_q;
  logic      hit_now;
  logic      hit_prev;

  // any valid writeback to this register
  function automatic logic wb_hit(
    input logic [NUM_WB-1:0]      valid,
    input reg_addr_t [NUM_WB-1:0] addr,
    input reg_addr_t              rd
  );
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < NUM_WB; i++)
    begin
      if (valid[i] && (addr[i] == rd))
      begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  // operand control, output held off while the sweep runs
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      oe_q    <= 1'b0;
      const_q <= 1'b0;
    end
    else if (rd_en)
    begin
      oe_q    <= rd_oe & ~wb.sweep_busy;
      const_q <= rd_const;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rd_en)
    begin
      addr_q <= rd_addr;
    end
  end

  assign look_addr = addr_q;

  // write-first bypass
  // current writebacks and the ones still on their way into the array
  assign hit_now  = wb_hit(wb.wb_valid, wb.wb_addr, addr_q);
  assign hit_prev = wb_hit(wb.wb_valid_d, wb.wb_addr_d, addr_q);

  always_comb
  begin
    if (!oe_q || const_q || hit_now || hit_prev)
    begin
      rd_data = 1'b0;
    end
    else
    begin
      rd_data = look_flag;
    end
  end

endmodule

`default_nettype wire

//--- src/inflight_top.sv
`timescale 1ns/1ps
`default_nettype none

module inflight_top
  import inflight_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,

  // read operands
  input  logic                      rd_en,
  input  reg_addr_t [NUM_READ-1:0]  rd_addr,
  input  logic [NUM_READ-1:0]       rd_oe,
  input  logic [NUM_READ-1:0]       rd_const,
  output logic [NUM_READ-1:0]       rd_data,

  // writebacks
  input  logic [NUM_WB-1:0]         wb_valid,
  input  reg_addr_t [NUM_WB-1:0]    wb_addr,

  // allocations
  input  logic [NUM_ALLOC-1:0]      alloc_valid,
  input  reg_addr_t [NUM_ALLOC-1:0] alloc_addr,

  output logic                      ready
);

  reg_addr_t [NUM_READ-1:0] look_addr;
  logic [NUM_READ-1:0]      look_flag;

  inflight_wb_if wb_if ();

  inflight_flags u_flags
  (
    .clk         (clk),
    .rst         (rst),
    .wb_valid    (wb_valid),
    .wb_addr     (wb_addr),
    .alloc_valid (alloc_valid),
    .alloc_addr  (alloc_addr),
    .look_addr   (look_addr),
    .look_flag   (look_flag),
    .wb          (wb_if),
    .ready       (ready)
  );

  // one port per source operand
  generate
    for (genvar p = 0; p < NUM_READ; p++)
    begin : g_read
      inflight_read_port u_read_port
      (
        .clk       (clk),
        .rst       (rst),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr[p]),
        .rd_oe     (rd_oe[p]),
        .rd_const  (rd_const[p]),
        .look_addr (look_addr[p]),
        .look_flag (look_flag[p]),
        .wb        (wb_if),
        .rd_data   (rd_data[p])
      );
    end
  endgenerate

endmodule

`default_nettype wire

//--- tests/inflight_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module inflight_assertions
  import inflight_pkg::*;
(
  input logic                clk,
  input logic                rst,
  input logic                ready,
  input logic [NUM_READ-1:0] rd_data
);

  // cycles since reset was released, saturating
  int cycles;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      cycles <= 0;
    end
    else if (cycles < NUM_REGS + 4)
    begin
      cycles <= cycles + 1;
    end
  end

  ready_held_low: assert property (@(posedge clk) disable iff (rst)
    (cycles < NUM_REGS) |-> !ready)
    else $error("ready rose before the sweep could finish");

  reads_zero_in_sweep: assert property (@(posedge clk) disable iff (rst)
    !ready |-> (rd_data == '0))
    else $error("rd_data nonzero while the sweep runs");

  ready_stays_high: assert property (@(posedge clk) disable iff (rst)
    ready |=> ready)
    else $error("ready fell after rising");

endmodule

`default_nettype wire

//--- tests/tb_inflight.sv
`timescale 1ns/1ps
`default_nettype none

module tb_inflight
  import inflight_pkg::*;
();

  localparam int    CLK_PERIOD  = 40;
  localparam int    RESET_CYCLES = 16;
  localparam int    WATCH_MARGIN = 20;
  localparam int    NUM_FIELDS  = 16;
  localparam string STIM_FILE   = "tests/inflight_stimulus.txt";

  logic                      clk;
  logic                      rst;
  logic                      rd_en;
  reg_addr_t [NUM_READ-1:0]  rd_addr;
  logic [NUM_READ-1:0]       rd_oe;
  logic [NUM_READ-1:0]       rd_const;
  logic [NUM_READ-1:0]       rd_data;
  logic [NUM_WB-1:0]         wb_valid;
  reg_addr_t [NUM_WB-1:0]    wb_addr;
  logic [NUM_ALLOC-1:0]      alloc_valid;
  reg_addr_t [NUM_ALLOC-1:0] alloc_addr;
  logic                      ready;

  // all stimulus rows, NUM_FIELDS values each
  logic [31:0] fields[$];
  int          num_lines;
  logic        loaded;
  int          mismatches;
  int          other_errors;

  inflight_top dut
  (
    .clk         (clk),
    .rst         (rst),
    .rd_en       (rd_en),
    .rd_addr     (rd_addr),
    .rd_oe       (rd_oe),
    .rd_const    (rd_const),
    .rd_data     (rd_data),
    .wb_valid    (wb_valid),
    .wb_addr     (wb_addr),
    .alloc_valid (alloc_valid),
    .alloc_addr  (alloc_addr),
    .ready       (ready)
  );

  bind inflight_top inflight_assertions u_assertions
  (
    .clk     (clk),
    .rst     (rst),
    .ready   (ready),
    .rd_data (rd_data)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("MISMATCH %s expected 0x%0h got 0x%0h at %0t", name, expected, actual, $time);
      mismatches++;
    end
  endtask

  task automatic load_stimulus();
    int          fd;
    int          count;
    string       line;
    logic [31:0] v [NUM_FIELDS];
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0)
    begin
      $display("could not open the stimulus file %s", STIM_FILE);
      other_errors++;
      return;
    end
    while (!$feof(fd))
    begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#")
      begin
        continue;
      end
      count = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                      v[8], v[9], v[10], v[11], v[12], v[13], v[14], v[15]);
      if (count != NUM_FIELDS)
      begin
        $display("stimulus line has %0d values instead of %0d", count, NUM_FIELDS);
        other_errors++;
        continue;
      end
      for (int f = 0; f < NUM_FIELDS; f++)
      begin
        fields.push_back(v[f]);
      end
    end
    $fclose(fd);
    num_lines = fields.size() / NUM_FIELDS;
  endtask

  // ends a run that never gets through the stimulus
  initial
  begin
    wait (loaded);
    #((RESET_CYCLES + NUM_REGS + num_lines + WATCH_MARGIN) * CLK_PERIOD);
    $display("timeout, the run did not finish in time");
    $display("Something failed");
    $finish;
  end

  initial
  begin
    int          base;
    logic [31:0] expected;
    logic [31:0] mask;
    rst         = 1'b1;
    rd_en       = 1'b0;
    rd_addr     = '0;
    rd_oe       = '0;
    rd_const    = '0;
    wb_valid    = '0;
    wb_addr     = '0;
    alloc_valid = '0;
    alloc_addr  = '0;
    mismatches   = 0;
    other_errors = 0;
    num_lines    = 0;
    loaded       = 1'b0;

    load_stimulus();
    loaded = 1'b1;

    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;

    // keep reading the last entries, which the sweep clears last
    rd_en      <= 1'b1;
    rd_oe      <= '1;
    rd_addr[0] <= 7'h7c;
    rd_addr[1] <= 7'h7d;
    rd_addr[2] <= 7'h7e;
    rd_addr[3] <= 7'h7f;

    // reads stay zero while the sweep runs
    @(negedge clk);
    while (!ready)
    begin
      compare_value("rd_data", 32'h0, 32'(rd_data));
      @(negedge clk);
    end

    for (int k = 0; k < num_lines; k++)
    begin
      base = k * NUM_FIELDS;
      @(posedge clk);
      rd_en       <= fields[base][0];
      rd_addr[0]  <= reg_addr_t'(fields[base + 1]);
      rd_addr[1]  <= reg_addr_t'(fields[base + 2]);
      rd_addr[2]  <= reg_addr_t'(fields[base + 3]);
      rd_addr[3]  <= reg_addr_t'(fields[base + 4]);
      rd_oe       <= fields[base + 5][NUM_READ-1:0];
      rd_const    <= fields[base + 6][NUM_READ-1:0];
      wb_valid    <= fields[base + 7][NUM_WB-1:0];
      wb_addr[0]  <= reg_addr_t'(fields[base + 8]);
      wb_addr[1]  <= reg_addr_t'(fields[base + 9]);
      wb_addr[2]  <= reg_addr_t'(fields[base + 10]);
      alloc_valid <= fields[base + 11][NUM_ALLOC-1:0];
      alloc_addr[0] <= reg_addr_t'(fields[base + 12]);
      alloc_addr[1] <= reg_addr_t'(fields[base + 13]);
      expected = fields[base + 14];
      mask     = fields[base + 15];
      @(negedge clk);
      for (int p = 0; p < NUM_READ; p++)
      begin
        if (mask[p])
        begin
          compare_value($sformatf("rd_data[%0d]", p), 32'(expected[p]), 32'(rd_data[p]));
        end
      end
    end

    if (num_lines == 0)
    begin
      $display("no stimulus lines were read");
      other_errors++;
    end

    $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0)
    begin
      $display("Everything OK");
    end
    else
    begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/inflight_stimulus.txt
# en a0 a1 a2 a3 oe const wbv wb0 wb1 wb2 alv al0 al1 exp mask (all hex)
# exp is rd_data seen in the same cycle; reads show the previous line's sample
1 00 01 02 03 f 0 0 00 00 00 0 00 00 0 f
1 04 05 06 07 f 0 0 00 00 00 0 00 00 0 f
1 08 09 0a 0b f 0 0 00 00 00 0 00 00 0 f
1 0c 0d 0e 0f f 0 0 00 00 00 0 00 00 0 f
1 10 11 12 13 f 0 0 00 00 00 0 00 00 0 f
1 14 15 16 17 f 0 0 00 00 00 0 00 00 0 f
1 18 19 1a 1b f 0 0 00 00 00 0 00 00 0 f
1 1c 1d 1e 1f f 0 0 00 00 00 0 00 00 0 f
1 20 21 22 23 f 0 0 00 00 00 0 00 00 0 f
1 24 25 26 27 f 0 0 00 00 00 0 00 00 0 f
1 28 29 2a 2b f 0 0 00 00 00 0 00 00 0 f
1 2c 2d 2e 2f f 0 0 00 00 00 0 00 00 0 f
1 30 31 32 33 f 0 0 00 00 00 0 00 00 0 f
1 34 35 36 37 f 0 0 00 00 00 0 00 00 0 f
1 38 39 3a 3b f 0 0 00 00 00 0 00 00 0 f
1 3c 3d 3e 3f f 0 0 00 00 00 0 00 00 0 f
1 40 41 42 43 f 0 0 00 00 00 0 00 00 0 f
1 44 45 46 47 f 0 0 00 00 00 0 00 00 0 f
1 48 49 4a 4b f 0 0 00 00 00 0 00 00 0 f
1 4c 4d 4e 4f f 0 0 00 00 00 0 00 00 0 f
1 50 51 52 53 f 0 0 00 00 00 0 00 00 0 f
1 54 55 56 57 f 0 0 00 00 00 0 00 00 0 f
1 58 59 5a 5b f 0 0 00 00 00 0 00 00 0 f
1 5c 5d 5e 5f f 0 0 00 00 00 0 00 00 0 f
1 60 61 62 63 f 0 0 00 00 00 0 00 00 0 f
1 64 65 66 67 f 0 0 00 00 00 0 00 00 0 f
1 68 69 6a 6b f 0 0 00 00 00 0 00 00 0 f
1 6c 6d 6e 6f f 0 0 00 00 00 0 00 00 0 f
1 70 71 72 73 f 0 0 00 00 00 0 00 00 0 f
1 74 75 76 77 f 0 0 00 00 00 0 00 00 0 f
1 78 79 7a 7b f 0 0 00 00 00 0 00 00 0 f
1 7c 7d 7e 7f f 0 0 00 00 00 0 00 00 0 f
1 10 20 30 40 f 0 0 00 00 00 3 10 20 0 f
1 10 20 30 40 f 0 0 00 00 00 3 30 40 3 f
1 10 20 30 40 f 0 0 00 00 00 0 00 00 f f
1 10 20 30 40 f 0 1 10 00 00 0 00 00 e f
1 10 20 30 40 f 0 0 00 00 00 0 00 00 e f
1 10 20 30 40 f 0 0 00 00 00 0 00 00 e f
1 10 20 30 40 f 0 1 20 00 00 0 00 00 c f
1 10 20 30 40 f 0 0 00 00 00 1 20 00 c f
1 10 20 30 40 f 0 0 00 00 00 0 00 00 e f
1 10 20 30 40 f 0 0 00 00 00 0 00 00 e f
1 10 20 30 40 d 4 0 00 00 00 0 00 00 e f
1 10 20 30 40 f 0 0 00 00 00 0 00 00 8 f
1 30 10 40 20 f 0 0 00 00 00 0 00 00 e f
0 00 00 00 00 0 0 0 00 00 00 0 00 00 d f
0 00 00 00 00 0 0 6 00 30 40 0 00 00 8 f
1 30 40 20 10 f 0 0 00 00 00 0 00 00 8 f
1 30 40 20 10 f 0 0 00 00 00 0 00 00 4 f
1 30 40 20 10 f 0 0 00 00 00 3 7f 00 4 f
1 7f 00 30 20 f 0 0 00 00 00 0 00 00 4 f
1 7f 00 30 20 f 0 0 00 00 00 0 00 00 b f
0 00 00 00 00 0 0 0 00 00 00 0 00 00 b f
0 00 00 00 00 0 0 4 00 00 7f 0 00 00 a f
0 00 00 00 00 0 0 0 00 00 00 0 00 00 a f
0 00 00 00 00 0 0 0 00 00 00 0 00 00 a f

//--- vlog.f
src/inflight_pkg.sv
src/inflight_wb_if.sv
src/inflight_flags.sv
src/inflight_read_port.sv
src/inflight_top.sv
tests/inflight_assertions.sv
tests/tb_inflight.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the inflight testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_inflight \
  --Mdir obj_dir -o sim_inflight \
  -f vlog.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_inflight > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Something failed" "$LOG"; then
  exit 1
fi

if ! grep -q "Everything OK" "$LOG"; then
  echo "simulation ended without a result"
  exit 1
fi

exit 0
